// ==== cpuDmaTop.f ====
hw/cpuDmaPkg.sv
hw/dmaCtlIf.sv
hw/dmaStrobeIf.sv
hw/cpuBusSync.sv
hw/cpuBusSequencer.sv
hw/cpuBusDrive.sv
hw/cpuDmaTop.sv
verification/cpuDmaTb.sv

// ==== hw/cpuBusDrive.sv ====
// registered output stage for bus and FIFO control strobes
module cpuBusDrive (
    input  logic          CLK135,
    input  logic          CCRESET_,
    dmaStrobeIf.driveSide strb,
    output logic          BREQ,
    output logic          BGACK,
    output logic          PAS,
    output logic          PDS,
    output logic          SIZE1,
    output logic          F2CPUL,
    output logic          F2CPUH,
    output logic          PLLW,
    output logic          PLHW,
    output logic          INCFIFO,
    output logic          DECFIFO,
    output logic          STOPFLUSH
);

    // every strobe leaves from a flop, so no decode glitches reach the bus
    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            BREQ      <= 1'b0;
            BGACK     <= 1'b0;
            PAS       <= 1'b0;
            PDS       <= 1'b0;
            SIZE1     <= 1'b0;
            F2CPUL    <= 1'b0;
            F2CPUH    <= 1'b0;
            PLLW      <= 1'b0;
            PLHW      <= 1'b0;
            INCFIFO   <= 1'b0;
            DECFIFO   <= 1'b0;
            STOPFLUSH <= 1'b0;
        end else begin
            BREQ      <= strb.breq;
            BGACK     <= strb.bgack;
            PAS       <= strb.pas;
            PDS       <= strb.pds;
            SIZE1     <= strb.size1;
            F2CPUL    <= strb.f2cpuL;
            F2CPUH    <= strb.f2cpuH;
            PLLW      <= strb.plLw;
            PLHW      <= strb.plHw;
            INCFIFO   <= strb.incFifo;      // one pulse per long word
            DECFIFO   <= strb.decFifo;
            STOPFLUSH <= strb.stopFlush;
        end
    end

endmodule

// ==== hw/cpuBusSequencer.sv ====
// arbitration and transfer-cycle FSM with 16-bit half tracking and strobe decode
module cpuBusSequencer (
    input  logic        CLK135,
    input  logic        CCRESET_,
    input  logic        DMADIR,         // high: FIFO to memory
    input  logic        FIFOEMPTY,
    input  logic        FIFOFULL,
    dmaCtlIf.seqSide    ctl,
    dmaStrobeIf.seqSide strb
);

    cpuDmaPkg::seqState state;
    cpuDmaPkg::seqState stateNext;
    cpuDmaPkg::halfSel  half;
    cpuDmaPkg::halfSel  halfNext;

    logic fifoOk;
    logic canRun;
    logic busCycle;
    logic termNow;
    logic wordDone;
    logic upper;

    assign fifoOk   = DMADIR ? !FIFOEMPTY : !FIFOFULL;      // room or data for one word
    assign canRun   = ctl.dmaEna && ctl.dreq && fifoOk && !ctl.flush;
    assign upper    = (half == cpuDmaPkg::UpperHalf);
    assign busCycle = (state == cpuDmaPkg::Address) || (state == cpuDmaPkg::Data);
    assign termNow  = (state == cpuDmaPkg::Data) && ctl.cycleDone;

    // long word complete after this termination
    assign wordDone = !upper || (ctl.size == cpuDmaPkg::Port32);

    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state <= cpuDmaPkg::Idle;
            half  <= cpuDmaPkg::UpperHalf;
        end else begin
            state <= stateNext;
            half  <= halfNext;
        end
    end

    always_comb begin
        stateNext = state;
        halfNext  = half;
        case (state)
            cpuDmaPkg::Idle: begin
                if (canRun) begin
                    stateNext = cpuDmaPkg::Request;
                end
            end
            cpuDmaPkg::Request: begin
                if (!canRun) begin
                    stateNext = cpuDmaPkg::Idle;                // request withdrawn
                end else if (ctl.bgrant && ctl.busFree) begin
                    stateNext = cpuDmaPkg::Own;
                end
            end
            cpuDmaPkg::Own: begin
                stateNext = cpuDmaPkg::Address;
            end
            cpuDmaPkg::Address: begin
                stateNext = cpuDmaPkg::Data;
            end
            cpuDmaPkg::Data: begin
                if (ctl.cycleDone) begin
                    stateNext = cpuDmaPkg::Finish;
                    halfNext  = wordDone ? cpuDmaPkg::UpperHalf : cpuDmaPkg::LowerHalf;
                end
            end
            cpuDmaPkg::Finish: begin
                // hold until the slave has let go of its termination
                if (!ctl.cycleDone) begin
                    if (!upper || canRun) begin
                        stateNext = cpuDmaPkg::Address;         // lower half or next word
                    end else begin
                        stateNext = cpuDmaPkg::Release;
                    end
                end
            end
            cpuDmaPkg::Release: begin
                stateNext = cpuDmaPkg::Idle;
            end
            default: begin
                stateNext = cpuDmaPkg::Idle;
            end
        endcase
    end

    // next values, registered in the drive stage
    assign strb.breq   = (state == cpuDmaPkg::Request);
    assign strb.bgack  = (state == cpuDmaPkg::Own) || busCycle ||
                         (state == cpuDmaPkg::Finish);
    assign strb.pas    = busCycle;
    assign strb.pds    = (state == cpuDmaPkg::Data);
    assign strb.size1  = busCycle && !upper;                    // word-sized second cycle

    // write side data enables follow PAS
    assign strb.f2cpuH = DMADIR && busCycle && upper;
    assign strb.f2cpuL = DMADIR && busCycle;

    // read side latches while data is still valid
    assign strb.plHw   = !DMADIR && termNow && upper;
    assign strb.plLw   = !DMADIR && termNow && wordDone;

    assign strb.incFifo = !DMADIR && termNow && wordDone;
    assign strb.decFifo = DMADIR && termNow && wordDone;

    assign strb.stopFlush = (state == cpuDmaPkg::Idle) && ctl.flush && FIFOEMPTY;

endmodule

// ==== hw/cpuBusSync.sv ====
// input synchronizers with termination decode for the CPU bus master
module cpuBusSync (
    input  logic        CLK135,
    input  logic        CCRESET_,
    input  logic        aBGRANT_,
    input  logic        aDMAENA,
    input  logic        aDREQ_,
    input  logic        aFLUSHFIFO,
    input  logic        AS_,
    input  logic        BGACK_I_,
    input  logic        DSACK0_,
    input  logic        DSACK1_,
    input  logic        STERM_,
    dmaCtlIf.syncSide   ctl
);

    logic       doneRaw;
    logic       sizeRaw;
    logic [6:0] rawIn;                              // all active high, zero when idle
    logic [6:0] syncReg [cpuDmaPkg::syncDepth];

    // decode before the chain so size and done arrive together
    assign doneRaw = !STERM_ || !DSACK0_ || !DSACK1_;
    assign sizeRaw = STERM_ && DSACK0_ && !DSACK1_;  // word port answers on DSACK1_ only

    assign rawIn = {
        sizeRaw,
        doneRaw,
        AS_ && BGACK_I_,                            // nobody else owns the bus
        aFLUSHFIFO,
        !aDREQ_,
        aDMAENA,
        !aBGRANT_
    };

    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            for (int i = 0; i < cpuDmaPkg::syncDepth; i++) begin
                syncReg[i] <= '0;
            end
        end else begin
            syncReg[0] <= rawIn;
            for (int i = 1; i < cpuDmaPkg::syncDepth; i++) begin
                syncReg[i] <= syncReg[i-1];
            end
        end
    end

    assign ctl.bgrant    = syncReg[cpuDmaPkg::syncDepth-1][0];
    assign ctl.dmaEna    = syncReg[cpuDmaPkg::syncDepth-1][1];
    assign ctl.dreq      = syncReg[cpuDmaPkg::syncDepth-1][2];
    assign ctl.flush     = syncReg[cpuDmaPkg::syncDepth-1][3];
    assign ctl.busFree   = syncReg[cpuDmaPkg::syncDepth-1][4];
    assign ctl.cycleDone = syncReg[cpuDmaPkg::syncDepth-1][5];
    assign ctl.size      = cpuDmaPkg::portSize'(syncReg[cpuDmaPkg::syncDepth-1][6]);

endmodule

// ==== hw/cpuDmaPkg.sv ====
// bus master package: synchronizer depth, sequencer state, port size and half select types
package cpuDmaPkg;

    // flops in each input synchronizer chain
    localparam int unsigned syncDepth = 2;

    // sequencer states
    typedef enum logic [2:0] {
        Idle    = 3'd0,     // waiting for a transfer request
        Request = 3'd1,     // BREQ out, waiting for grant
        Own     = 3'd2,     // BGACK taken
        Address = 3'd3,     // address strobe phase
        Data    = 3'd4,     // data strobe until termination
        Finish  = 3'd5,     // strobes off, wait for termination release
        Release = 3'd6      // BGACK dropped
    } seqState;

    // port width reported by the termination
    typedef enum logic {
        Port32 = 1'b0,      // STERM_ or both DSACKs
        Port16 = 1'b1       // DSACK1_ alone
    } portSize;

    // which half of the long word is on the bus
    typedef enum logic {
        UpperHalf = 1'b0,   // first cycle, also whole long word on a 32-bit port
        LowerHalf = 1'b1    // second cycle on a 16-bit port
    } halfSel;

endpackage

// ==== hw/cpuDmaTop.sv ====
// top level of the DMA CPU bus master joining sync, sequencer and drive stages
module cpuDmaTop (
    input  logic CLK135,
    input  logic CCRESET_,
    input  logic aBGRANT_,
    input  logic aDMAENA,
    input  logic aDREQ_,
    input  logic aFLUSHFIFO,
    input  logic AS_,
    input  logic BGACK_I_,
    input  logic DSACK0_,
    input  logic DSACK1_,
    input  logic STERM_,
    input  logic DMADIR,
    input  logic FIFOEMPTY,
    input  logic FIFOFULL,
    output logic BREQ,
    output logic BGACK,
    output logic PAS,
    output logic PDS,
    output logic SIZE1,
    output logic F2CPUL,
    output logic F2CPUH,
    output logic PLLW,
    output logic PLHW,
    output logic INCFIFO,
    output logic DECFIFO,
    output logic STOPFLUSH
);

    dmaCtlIf    ctl ();     // synchronized levels
    dmaStrobeIf strb ();    // next-cycle strobes

    cpuBusSync uBusSync (
        .CLK135     (CLK135),
        .CCRESET_   (CCRESET_),
        .aBGRANT_   (aBGRANT_),
        .aDMAENA    (aDMAENA),
        .aDREQ_     (aDREQ_),
        .aFLUSHFIFO (aFLUSHFIFO),
        .AS_        (AS_),
        .BGACK_I_   (BGACK_I_),
        .DSACK0_    (DSACK0_),
        .DSACK1_    (DSACK1_),
        .STERM_     (STERM_),
        .ctl        (ctl.syncSide)
    );

    cpuBusSequencer uBusSequencer (
        .CLK135     (CLK135),
        .CCRESET_   (CCRESET_),
        .DMADIR     (DMADIR),
        .FIFOEMPTY  (FIFOEMPTY),
        .FIFOFULL   (FIFOFULL),
        .ctl        (ctl.seqSide),
        .strb       (strb.seqSide)
    );

    cpuBusDrive uBusDrive (
        .CLK135     (CLK135),
        .CCRESET_   (CCRESET_),
        .strb       (strb.driveSide),
        .BREQ       (BREQ),
        .BGACK      (BGACK),
        .PAS        (PAS),
        .PDS        (PDS),
        .SIZE1      (SIZE1),
        .F2CPUL     (F2CPUL),
        .F2CPUH     (F2CPUH),
        .PLLW       (PLLW),
        .PLHW       (PLHW),
        .INCFIFO    (INCFIFO),
        .DECFIFO    (DECFIFO),
        .STOPFLUSH  (STOPFLUSH)
    );

endmodule

// ==== hw/dmaCtlIf.sv ====
// interface with synchronized request and termination levels for the sequencer
interface dmaCtlIf;

    logic                 bgrant;     // bus grant, active high
    logic                 dmaEna;
    logic                 dreq;       // transfer request, active high
    logic                 flush;
    logic                 busFree;    // AS_ and BGACK_I_ both released
    logic                 cycleDone;  // any termination seen
    cpuDmaPkg::portSize   size;

    modport syncSide (
        output bgrant,
        output dmaEna,
        output dreq,
        output flush,
        output busFree,
        output cycleDone,
        output size
    );

    modport seqSide (
        input bgrant,
        input dmaEna,
        input dreq,
        input flush,
        input busFree,
        input cycleDone,
        input size
    );

endinterface

// ==== hw/dmaStrobeIf.sv ====
// interface with next-cycle control strobes from the sequencer to the output registers
interface dmaStrobeIf;

    logic breq;
    logic bgack;
    logic pas;
    logic pds;
    logic size1;
    logic f2cpuL;     // FIFO low word onto bus
    logic f2cpuH;     // FIFO high word onto bus
    logic plLw;       // latch low word from bus
    logic plHw;       // latch high word from bus
    logic incFifo;
    logic decFifo;
    logic stopFlush;

    modport seqSide (
        output breq, bgack, pas, pds, size1,
        output f2cpuL, f2cpuH, plLw, plHw,
        output incFifo, decFifo, stopFlush
    );

    modport driveSide (
        input breq, bgack, pas, pds, size1,
        input f2cpuL, f2cpuH, plLw, plHw,
        input incFifo, decFifo, stopFlush
    );

endinterface

// ==== verification/cpuDmaTb.sv ====
// DMA CPU bus master testbench with bus responder, pulse monitor, directed tests and watchdog
module cpuDmaTb;

    logic        CLK135 = 1'b0;
    logic        CCRESET_ = 1'b0;
    logic        aBGRANT_ = 1'b1;
    logic        aDMAENA = 1'b0;
    logic        aDREQ_ = 1'b1;
    logic        aFLUSHFIFO = 1'b0;
    logic        AS_ = 1'b1;
    logic        BGACK_I_ = 1'b1;
    logic        DSACK0_ = 1'b1;
    logic        DSACK1_ = 1'b1;
    logic        STERM_ = 1'b1;
    logic        DMADIR = 1'b0;
    logic        FIFOEMPTY = 1'b0;
    logic        FIFOFULL = 1'b0;
    logic BREQ, BGACK, PAS, PDS, SIZE1, F2CPUL, F2CPUH, PLLW, PLHW, INCFIFO, DECFIFO, STOPFLUSH;
    logic [11:0] outs;                  // bit 0 BREQ, bit 1 BGACK, bit 11 STOPFLUSH
    logic [1:0]  termMode = 2'd0;       // 0 STERM_, 1 both DSACKs, 2 DSACK1_ alone
    logic        termOn = 1'b0;
    logic        pasPrev = 1'b0;
    logic [31:0] rng = 32'd7;
    int          termWait = 0;
    int          counts [7] = '{default: 0};   // INCFIFO DECFIFO PLLW PLHW PAS PAS+SIZE1 BREQ
    int          errCount = 0;
    int          passCount = 0;
    int          failCount = 0;

    assign outs = {STOPFLUSH, DECFIFO, INCFIFO, PLHW, PLLW, F2CPUH, F2CPUL,
                   SIZE1, PDS, PAS, BGACK, BREQ};

    cpuDmaTop u_cpuDmaTop (.*);

    always #2 CLK135 = !CLK135;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // slave model answering BREQ with a grant and PDS with a termination after a random wait
    always @(posedge CLK135) begin
        aBGRANT_ <= !(BREQ === 1'b1);
        if (PDS === 1'b1 && !termOn) begin
            if (termWait == 0) begin
                termOn  <= 1'b1;
                STERM_  <= (termMode != 2'd0);
                DSACK0_ <= (termMode != 2'd1);
                DSACK1_ <= (termMode == 2'd0);
            end else begin
                termWait <= termWait - 1;
            end
        end else if (PDS === 1'b0 && termOn) begin
            termOn  <= 1'b0;            // let go once the strobe is gone
            STERM_  <= 1'b1;
            DSACK0_ <= 1'b1;
            DSACK1_ <= 1'b1;
            rng = xorshift(rng);
            termWait <= rng % 4;
        end
    end

    // pulse counters and strobe checks sampled mid-cycle
    always @(negedge CLK135) begin
        logic expL;
        logic expH;
        expL = (PAS === 1'b1 && DMADIR === 1'b1);   // write data enabled with PAS
        expH = expL && SIZE1 !== 1'b1;              // high word off in the lower-half cycle
        counts[0] += (INCFIFO === 1'b1);
        counts[1] += (DECFIFO === 1'b1);
        counts[2] += (PLLW === 1'b1);
        counts[3] += (PLHW === 1'b1);
        counts[4] += (PAS === 1'b1 && !pasPrev);
        counts[5] += (PAS === 1'b1 && !pasPrev && SIZE1 === 1'b1);
        counts[6] += (BREQ === 1'b1);
        pasPrev = (PAS === 1'b1);
        assert (PAS !== 1'b1 || BGACK === 1'b1) else begin
            $display("PAS was driven while BGACK was low");
            errCount++;
        end
        assert (F2CPUL === expL && F2CPUH === expH) else begin
            $display("Error: F2CPUL 0x%0h F2CPUH 0x%0h expected 0x%0h 0x%0h",
                     F2CPUL, F2CPUH, expL, expH);
            errCount++;
        end
    end

    task automatic waitLevel(input int idx, input logic level, input int limit, input string what);
        int n;
        n = 0;
        @(negedge CLK135);
        while (outs[idx] !== level && n < limit) begin
            @(negedge CLK135);
            n++;
        end
        assert (outs[idx] === level) else begin
            $display("timed out waiting for %s", what);
            errCount++;
        end
    endtask

    task automatic checkCount(input string name, input int got, input int expected);
        assert (got == expected) else begin
            $display("Error: %s pulses 0x%0h expected 0x%0h", name, got, expected);
            errCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errBase);
        if (errCount == errBase) begin
            passCount++;
            $display("test %s passed", name);
        end else begin
            failCount++;
            $display("test %s failed with %0d errors", name, errCount - errBase);
        end
    endtask

    // transfer until enough FIFO pulses, drop the request, then compare pulse counts
    task automatic moveWords(input logic dir, input logic [1:0] mode, input int words,
                             input int halves);
        int base [7];
        int n;
        base = counts;
        n = 0;
        DMADIR   <= dir;
        termMode <= mode;
        aDMAENA  <= 1'b1;
        aDREQ_   <= 1'b0;
        while (counts[0] + counts[1] - base[0] - base[1] < words && n < words * 60) begin
            @(posedge CLK135);
            n++;
        end
        aDREQ_ <= 1'b1;
        waitLevel(1, 1'b0, 60, "BGACK to fall after the request was removed");
        repeat (8) @(posedge CLK135);
        checkCount("INCFIFO", counts[0] - base[0], dir ? 0 : words);
        checkCount("DECFIFO", counts[1] - base[1], dir ? words : 0);
        checkCount("PLLW", counts[2] - base[2], dir ? 0 : words);
        checkCount("PLHW", counts[3] - base[3], dir ? 0 : words);
        checkCount("PAS", counts[4] - base[4], words * halves);
        checkCount("SIZE1", counts[5] - base[5], words * (halves - 1));
    endtask

    task automatic resetBehavior();
        int errBase;
        errBase = errCount;
        for (int i = 0; i < 16; i++) begin
            @(posedge CLK135);
            CCRESET_ <= (i >= 4);       // low over the first five edges
            aDREQ_   <= (i < 4);        // request with enable still off
            @(negedge CLK135);
            assert (outs === 12'h000) else begin
                $display("Error: outs 0x%03h expected 0x000 in cycle %0d", outs, i);
                errCount++;
            end
        end
        reportTest("reset", errBase);
    endtask

    task automatic busArbitration();
        int errBase;
        errBase = errCount;
        @(posedge CLK135);
        termMode <= 2'd1;
        BGACK_I_ <= 1'b0;               // another master still holds the bus
        aDMAENA  <= 1'b1;
        aDREQ_   <= 1'b0;
        waitLevel(0, 1'b1, 20, "BREQ to rise");
        repeat (8) @(negedge CLK135);
        assert (BGACK === 1'b0 && BREQ === 1'b1) else begin
            $display("bus ownership was taken while another master held the bus");
            errCount++;
        end
        @(posedge CLK135);
        BGACK_I_ <= 1'b1;
        waitLevel(1, 1'b1, 20, "BGACK to rise");
        assert (BREQ === 1'b0) else begin
            $display("Error: BREQ 0x%0h expected 0x0 with BGACK high", BREQ);
            errCount++;
        end
        @(posedge CLK135);
        aDREQ_ <= 1'b1;
        waitLevel(1, 1'b0, 60, "BGACK to fall");
        repeat (8) @(posedge CLK135);
        reportTest("arbitration", errBase);
    endtask

    task automatic longWordRead();
        int errBase;
        errBase = errCount;
        @(posedge CLK135);
        moveWords(1'b0, 2'd0, 4, 1);
        reportTest("32-bit read", errBase);
    endtask

    task automatic wordPortWrite();
        int errBase;
        errBase = errCount;
        @(posedge CLK135);
        moveWords(1'b1, 2'd2, 3, 2);
        reportTest("16-bit write", errBase);
    endtask

    task automatic fifoLimitsFlush();
        int errBase;
        int base [7];
        errBase = errCount;
        @(posedge CLK135);
        base = counts;
        DMADIR   <= 1'b0;
        FIFOFULL <= 1'b1;               // read with no room left
        aDMAENA  <= 1'b1;
        aDREQ_   <= 1'b0;
        repeat (20) @(posedge CLK135);
        FIFOFULL   <= 1'b0;
        DMADIR     <= 1'b1;
        FIFOEMPTY  <= 1'b1;
        aFLUSHFIFO <= 1'b1;
        waitLevel(11, 1'b1, 20, "STOPFLUSH to rise");
        repeat (10) @(negedge CLK135);
        assert (STOPFLUSH === 1'b1) else begin
            $display("STOPFLUSH dropped while the flush was still requested");
            errCount++;
        end
        @(posedge CLK135);
        aFLUSHFIFO <= 1'b0;
        waitLevel(11, 1'b0, 20, "STOPFLUSH to fall");
        @(posedge CLK135);
        aDREQ_    <= 1'b1;
        FIFOEMPTY <= 1'b0;
        checkCount("BREQ", counts[6] - base[6], 0);
        checkCount("PAS", counts[4] - base[4], 0);
        reportTest("FIFO limits and flush", errBase);
    endtask

    initial begin
        resetBehavior();
        busArbitration();
        longWordRead();
        wordPortWrite();
        fifoLimitsFlush();
        $display("tests passed %0d failed %0d", passCount, failCount);
        if (failCount == 0 && errCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // reset 16, arbitration 110, ten bus cycles at 40, limits 80, all doubled
    initial begin
        #(2 * (16 + 110 + 10 * 40 + 80) * 4);
        $display("watchdog expired before the tests completed");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
